// ==== compile.f ====
+incdir+rtl
rtl/pi_ctrl_pkg.sv
rtl/pi_cmd_if.sv
rtl/pi_step_decode.sv
rtl/pi_phase_accum.sv
rtl/pi_code_decode.sv
rtl/pi_ctrl_top.sv
testbench/tb_pi_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the interpolator control path

VERILATOR ?= verilator
TOP       ?= tb_pi_ctrl
FILELIST  ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)
SIM     := $(BUILD)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tb_pi_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pi_ctrl_macros.svh"

module tb_pi_ctrl;
  import pi_ctrl_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYC  = 3;
  localparam int RAND_CYC   = 400;
  localparam int WALK_CYC   = 17 * 8;       // load plus 16 steps, 8 cycles each
  localparam int TOTAL_CYC  = RESET_CYC + RAND_CYC + 2 * WALK_CYC + 8 + 30;
  localparam int HIST_LEN   = 2048;         // per-edge model history

  logic       clk;
  logic       reset;
  logic       enable;
  logic       step_up;
  logic       step_dn;
  logic       load;
  logic       test_enable;
  pi_phase_t  load_code;
  pi_filter_t filter_code;
  pi_phase_t  phase_code;
  pi_thermo_t sp;
  pi_thermo_t sn;
  pi_sel_t    selp;
  pi_sel_t    seln;
  pi_cap_t    scp;
  pi_cap_t    scn;

  logic [31:0] lcg_state = 32'hb4f9_bb77;
  int          cyc;                         // rising edges seen so far
  int          errors;
  int          checks;
  int          hold_cnt;                    // model hold-off, cycles left
  pi_phase_t   pos_now;                     // model position, no latency
  pi_phase_t   lpos [HIST_LEN];             // pos_now after each edge
  bit          en_h [HIST_LEN];             // enable seen at each edge
  logic        test_q;                      // test level as registered
  pi_filter_t  filt_q;

  pi_ctrl_top DUT (
    .clk, .reset, .enable, .step_up, .step_dn, .load, .load_code,
    .test_enable, .filter_code, .phase_code,
    .sp, .sn, .selp, .seln, .scp, .scn
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pi_phase_t past_pos(int idx);
    return (idx < 1) ? 4'd0 : lpos[idx];    // before the first edge, position 0
  endfunction

  function automatic pi_thermo_t thermo_of(pi_phase_t p);
    int n;
    n = int'(p);
    if (n > 8) n = 16 - n;                  // top half folds back down
    return pi_thermo_t'((9'd1 << n) - 9'd1);
  endfunction

  function automatic pi_sel_t seln_of(pi_phase_t p, logic tst);
    logic    g3;
    logic    g2;
    pi_sel_t s;
    g3 = p[3];                              // gray bit 3
    g2 = p[3] ^ p[2];                       // gray bit 2
    if (!tst) s = g3 ? 7'b101_1010 : 7'b101_0011;
    else if ({g3, g2} == 2'b00) s = 7'b000_0011;
    else if ({g3, g2} == 2'b10) s = 7'b100_1000;
    else s = 7'b001_0000;                   // 01 and 11
    return s;
  endfunction

  function automatic pi_cap_t cap_of(pi_filter_t f);
    return pi_cap_t'((4'd1 << f) - 4'd1);   // 000, 001, 011, 111
  endfunction

  // one rising edge of the model, using the inputs the DUT just sampled
  task automatic model_edge();
    logic req_ok;
    cyc++;
    req_ok = load || (step_up != step_dn);  // up+down alone is no request
    en_h[cyc] = enable && !reset;
    if (reset) begin
      hold_cnt = 0;
      pos_now  = 4'd0;
      test_q   = 1'b0;
      filt_q   = 2'd0;
    end else begin
      test_q = test_enable;
      filt_q = filter_code;
      if (hold_cnt > 0) hold_cnt--;         // settling, request dropped
      else if (req_ok) begin
        hold_cnt = `PI_STEP_GAP;
        if (load) pos_now = load_code;
        else if (step_up) pos_now = pos_now + 4'd1;
        else pos_now = pos_now - 4'd1;
      end
    end
    lpos[cyc] = pos_now;
  endtask

  task automatic check_value(string what, logic [7:0] got, logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    pi_phase_t  dec_pos;
    pi_thermo_t exp_sp;
    pi_thermo_t exp_sn;
    pi_sel_t    exp_seln;
    pi_sel_t    exp_selp;
    pi_cap_t    exp_scn;
    pi_cap_t    exp_scp;
    // two sync stages, both must have seen enable
    dec_pos  = (en_h[cyc] && en_h[cyc-1]) ? past_pos(cyc - 4) : 4'd0;
    exp_sp   = thermo_of(dec_pos);
    exp_sn   = ~exp_sp;
    exp_seln = seln_of(dec_pos, test_q);
    exp_selp = ~exp_seln;
    exp_scn  = cap_of(filt_q);
    exp_scp  = ~exp_scn;
    check_value("phase_code", 8'(phase_code), 8'(past_pos(cyc - 2)));
    check_value("sp", sp, exp_sp);
    check_value("sn", sn, exp_sn);
    check_value("seln", 8'(seln), 8'(exp_seln));
    check_value("selp", 8'(selp), 8'(exp_selp));
    check_value("scn", 8'(scn), 8'(exp_scn));
    check_value("scp", 8'(scp), 8'(exp_scp));
  endtask

  // ------------------------------------------------------------------------
  // stimulus, one call per clock, from falling edge to falling edge
  // ------------------------------------------------------------------------
  task automatic run_cycle(logic up, logic dn, logic ld, pi_phase_t code);
    step_up   = up;
    step_dn   = dn;
    load      = ld;
    load_code = code;
    @(posedge clk);
    model_edge();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic walk_positions(logic tst);
    test_enable = tst;
    repeat (7) run_cycle(1'b0, 1'b0, 1'b0, 4'd0);    // let any hold-off run out
    run_cycle(1'b0, 1'b0, 1'b1, 4'd0);
    repeat (16) begin                                // ends back at 0 via 15
      repeat (7) run_cycle(1'b0, 1'b0, 1'b0, 4'd0);
      run_cycle(1'b1, 1'b0, 1'b0, 4'd0);
    end
  endtask

  initial begin
    logic [31:0] r;
    reset       = 1'b1;
    enable      = 1'b1;
    step_up     = 1'b0;
    step_dn     = 1'b0;
    load        = 1'b0;
    load_code   = 4'd0;
    test_enable = 1'b0;
    filter_code = 2'd0;
    cyc         = 0;
    errors      = 0;
    checks      = 0;
    hold_cnt    = 0;
    pos_now     = 4'd0;
    test_q      = 1'b0;
    filt_q      = 2'd0;
    repeat (RESET_CYC) run_cycle(1'b0, 1'b0, 1'b0, 4'd0);
    reset = 1'b0;
    check_value("sp after reset", sp, 8'h00);
    check_value("sn after reset", sn, 8'hff);
    check_value("scn after reset", 8'(scn), 8'h00);
    check_value("phase_code after reset", 8'(phase_code), 8'h00);

    // random requests, collisions and hold-off drops included
    for (int i = 0; i < RAND_CYC; i++) begin
      r = lcg_next();
      filter_code = r[13:12];
      test_enable = (r[17:15] == 3'd0);
      case (r[2:0])
        3'd0, 3'd1: run_cycle(1'b1, 1'b0, 1'b0, r[11:8]);
        3'd2, 3'd3: run_cycle(1'b0, 1'b1, 1'b0, r[11:8]);
        3'd4:       run_cycle(r[5], r[6], 1'b1, r[11:8]);  // load wins
        3'd5:       run_cycle(1'b1, 1'b1, 1'b0, r[11:8]);
        default:    run_cycle(1'b0, 1'b0, 1'b0, r[11:8]);
      endcase
    end

    filter_code = 2'd0;
    walk_positions(1'b0);
    walk_positions(1'b1);                   // test mode decode
    test_enable = 1'b0;

    for (int f = 0; f < 4; f++) begin
      filter_code = pi_filter_t'(f);
      repeat (2) run_cycle(1'b0, 1'b0, 1'b0, 4'd0);
    end

    // sync held clear, position keeps moving
    enable = 1'b0;
    repeat (3) begin
      run_cycle(1'b1, 1'b0, 1'b0, 4'd0);
      repeat (7) run_cycle(1'b0, 1'b0, 1'b0, 4'd0);
    end
    enable = 1'b1;
    repeat (6) run_cycle(1'b0, 1'b0, 1'b0, 4'd0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("Simulation PASSED");
    else $display("Simulation FAILED");
    $finish;
  end

  // watchdog
  initial begin
    #((TOTAL_CYC + 100) * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", TOTAL_CYC + 100);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/pi_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pi_ctrl_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  logic                    step_up,
  input  logic                    step_dn,
  input  logic                    load,
  input  pi_ctrl_pkg::pi_phase_t  load_code,
  input  logic                    test_enable,
  input  pi_ctrl_pkg::pi_filter_t filter_code,
  output pi_ctrl_pkg::pi_phase_t  phase_code,
  output pi_ctrl_pkg::pi_thermo_t sp,
  output pi_ctrl_pkg::pi_thermo_t sn,
  output pi_ctrl_pkg::pi_sel_t    selp,
  output pi_ctrl_pkg::pi_sel_t    seln,
  output pi_ctrl_pkg::pi_cap_t    scp,
  output pi_ctrl_pkg::pi_cap_t    scn
);
  import pi_ctrl_pkg::*;

  pi_gray_t gray_code;   // execute to result hand-over
  logic     gray_upd;

  pi_cmd_if cmd_bus ();  // decode to execute

  pi_step_decode u_step_decode (
    .clk, .reset, .step_up, .step_dn, .load, .load_code, .test_enable,
    .cmd (cmd_bus.master)
  );

  pi_phase_accum u_phase_accum (
    .clk, .reset,
    .cmd (cmd_bus.slave),
    .phase_code, .gray_code, .gray_upd
  );

  // test level rides the command bus
  pi_code_decode u_code_decode (
    .clk, .reset, .enable, .gray_code, .gray_upd,
    .test (cmd_bus.test),
    .filter_code,
    .sp, .sn, .selp, .seln, .scp, .scn
  );

endmodule

`default_nettype wire

// ==== rtl/pi_code_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module pi_code_decode (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,       // low forces decode of gray 0
  input  pi_ctrl_pkg::pi_gray_t   gray_code,
  input  logic                    gray_upd,
  input  logic                    test,         // test mode level
  input  pi_ctrl_pkg::pi_filter_t filter_code,
  output pi_ctrl_pkg::pi_thermo_t sp,
  output pi_ctrl_pkg::pi_thermo_t sn,
  output pi_ctrl_pkg::pi_sel_t    selp,
  output pi_ctrl_pkg::pi_sel_t    seln,
  output pi_ctrl_pkg::pi_cap_t    scp,
  output pi_ctrl_pkg::pi_cap_t    scn
);
  import pi_ctrl_pkg::*;

  pi_gray_t   sync1;       // first sync stage
  pi_gray_t   sync2;       // second sync stage, drives all decode
  pi_filter_t filter_q;
  pi_phase_t  bin;         // sync2 back in binary
  logic [3:0] ones;        // thermometer length, 0..8
  logic [3:0] upd_cnt;     // running count of gray updates

  // ------------------------------------------------------------------------
  // gray sync, cleared while disabled
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      sync1 <= '0;
      sync2 <= '0;
    end else begin
      sync1 <= gray_code;
      sync2 <= sync1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      filter_q <= '0;
      upd_cnt  <= '0;
    end else begin
      filter_q <= filter_code;
      if (gray_upd) upd_cnt <= upd_cnt + 4'd1;
    end
  end

  // ------------------------------------------------------------------------
  // eight-phase thermometer
  // ------------------------------------------------------------------------
  always_comb begin
    bin[3] = sync2[3];
    for (int i = 2; i >= 0; i--) bin[i] = bin[i+1] ^ sync2[i];
    ones = (bin <= 4'd8) ? bin : 4'd0 - bin;  // 16 - p folds the top half
    for (int i = 0; i < 8; i++) sp[i] = (i < ones);
  end

  assign sn = ~sp;

  // ------------------------------------------------------------------------
  // two-phase select, with the special test decode
  // ------------------------------------------------------------------------
  always_comb begin
    casez ({sync2[3:2], test})
      3'b0?0:  seln = 7'b101_0011;  // interpolate a and b
      3'b1?0:  seln = 7'b101_1010;  // interpolate b and c
      3'b001:  seln = 7'b000_0011;  // clk a only
      3'b111:  seln = 7'b001_0000;  // clk b only
      3'b011:  seln = 7'b001_0000;  // clk b only
      default: seln = 7'b100_1000;  // 101, clk c only
    endcase
  end

  assign selp = ~seln;

  // filter capacitance, more caps for slower bands
  always_comb begin
    case (filter_q)
      2'd0:    scn = 3'b000;
      2'd1:    scn = 3'b001;
      2'd2:    scn = 3'b011;
      default: scn = 3'b111;
    endcase
  end

  assign scp = ~scn;

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  // stage 2 moves only two cycles after an update or around an enable edge
  a_sync_cause: assert property (@(posedge clk) disable iff (reset)
    $changed(sync2) |-> ($past(upd_cnt) != $past(upd_cnt, 2)) ||
                        ($past(enable) != $past(enable, 3)));

  // thermometer never has holes
  a_thermo_run: assert property (@(posedge clk) disable iff (reset)
    ((sp + 8'd1) & sp) == 8'd0);

endmodule

`default_nettype wire

// ==== rtl/pi_phase_accum.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pi_ctrl_macros.svh"

module pi_phase_accum (
  input  logic                   clk,
  input  logic                   reset,
  pi_cmd_if.slave                cmd,
  output pi_ctrl_pkg::pi_phase_t phase_code,
  output pi_ctrl_pkg::pi_gray_t  gray_code,
  output logic                   gray_upd
);
  import pi_ctrl_pkg::*;

  pi_phase_t phase_nxt;  // position after this cycle's command
  pi_gray_t  gray_nxt;

  // ------------------------------------------------------------------------
  // position update, modulo 16
  // ------------------------------------------------------------------------
  always_comb begin
    phase_nxt = phase_code;
    if (cmd.valid) begin
      case (cmd.op)
        `PI_OP_UP:   phase_nxt = phase_code + 4'd1;  // 15 wraps to 0
        `PI_OP_DN:   phase_nxt = phase_code - 4'd1;  // 0 wraps to 15
        `PI_OP_LOAD: phase_nxt = cmd.code;
        default:     phase_nxt = phase_code;         // unused code, hold
      endcase
    end
  end

  // reflected gray, one bit flips per step
  assign gray_nxt = pi_gray_t'(phase_nxt ^ (phase_nxt >> 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_code <= '0;
      gray_code  <= '0;
      gray_upd   <= 1'b0;
    end else begin
      phase_code <= phase_nxt;
      gray_code  <= gray_nxt;        // registered with the position
      gray_upd   <= cmd.valid;       // marks the new gray_code cycle
    end
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  // a single step never moves more than one gray bit, wrap included;
  // the interpolator relies on this to avoid glitching phases
  a_gray_one_bit: assert property (@(posedge clk) disable iff (reset)
    cmd.valid && (cmd.op == `PI_OP_UP || cmd.op == `PI_OP_DN)
    |=> $countones(gray_code ^ $past(gray_code)) == 1);

endmodule

`default_nettype wire

// ==== rtl/pi_step_decode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pi_ctrl_macros.svh"

module pi_step_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  step_up,
  input  logic                  step_dn,
  input  logic                  load,
  input  pi_ctrl_pkg::pi_phase_t load_code,
  input  logic                  test_enable,
  pi_cmd_if.master              cmd
);
  import pi_ctrl_pkg::*;

  localparam int unsigned GAP_W = $clog2(`PI_STEP_GAP + 1);

  logic             up_q;      // registered requests
  logic             dn_q;
  logic             ld_q;
  pi_phase_t        code_q;    // registered load target
  logic             take;      // request accepted this cycle
  pi_op_t           op_nxt;
  pi_hold_e         state;
  logic [GAP_W-1:0] gap_cnt;   // remaining hold-off cycles

  // ------------------------------------------------------------------------
  // request capture
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      up_q <= 1'b0;
      dn_q <= 1'b0;
      ld_q <= 1'b0;
    end else begin
      up_q <= step_up;
      dn_q <= step_dn;
      ld_q <= load;
    end
  end

  always_ff @(posedge clk) code_q <= load_code;

  // priority: load first, then a lone up or down; up+down is ignored
  always_comb begin
    take   = 1'b0;
    op_nxt = `PI_OP_UP;
    if (ld_q) begin
      take   = 1'b1;
      op_nxt = `PI_OP_LOAD;
    end else if (up_q && !dn_q) begin
      take   = 1'b1;
    end else if (dn_q && !up_q) begin
      take   = 1'b1;
      op_nxt = `PI_OP_DN;
    end
    if (state != HOLD_IDLE) take = 1'b0;  // settling, drop everything
  end

  // ------------------------------------------------------------------------
  // hold-off FSM and command register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= HOLD_IDLE;
      gap_cnt   <= '0;
      cmd.valid <= 1'b0;
      cmd.test  <= 1'b0;
    end else begin
      cmd.valid <= take;
      cmd.test  <= test_enable;       // level, follows the pin
      case (state)
        HOLD_IDLE: if (take) begin
          state   <= HOLD_WAIT;
          gap_cnt <= GAP_W'(`PI_STEP_GAP - 1);
        end
        HOLD_WAIT: if (gap_cnt == '0) state <= HOLD_IDLE;
                   else gap_cnt <= gap_cnt - 1'b1;
        default:   state <= HOLD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    cmd.op   <= op_nxt;              // payload, qualified by valid
    cmd.code <= code_q;
  end

  // spacing between commands seen by the execute stage
  a_step_gap: assert property (@(posedge clk) disable iff (reset)
    cmd.valid |=> !cmd.valid [*`PI_STEP_GAP]);

endmodule

`default_nettype wire

// ==== rtl/pi_cmd_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one phase command per strobe, no back-pressure
interface pi_cmd_if;
  import pi_ctrl_pkg::*;

  logic      valid;  // single cycle strobe
  pi_op_t    op;     // PI_OP_* code, only meaningful with valid
  pi_phase_t code;   // load target, only meaningful with valid
  logic      test;   // registered test mode level

  // decode side
  modport master (
    output valid, op, code, test
  );

  // execute side
  modport slave (
    input valid, op, code, test
  );

endinterface

`default_nettype wire

// ==== rtl/pi_ctrl_pkg.sv ====
`default_nettype none

package pi_ctrl_pkg;

  // ------------------------------------------------------------------------
  // phase position and its encodings
  // ------------------------------------------------------------------------
  typedef logic [3:0] pi_phase_t;   // binary position 0..15, wraps
  typedef logic [3:0] pi_gray_t;    // reflected gray of pi_phase_t

  typedef logic [1:0] pi_op_t;      // holds one PI_OP_* code

  // interpolator control codes
  typedef logic [7:0] pi_thermo_t;  // thermometer for the eight-phase stage
  typedef logic [6:0] pi_sel_t;     // two-phase stage select

  // filter band and the capacitance selection it maps to
  // 0 = fastest band, 3 = slowest band
  typedef logic [1:0] pi_filter_t;
  typedef logic [3:1] pi_cap_t;     // bits 3 down to 1, as on the macro

  // step hold-off machine
  typedef enum logic {
    HOLD_IDLE,                      // requests may be taken
    HOLD_WAIT                       // settling, requests dropped
  } pi_hold_e;

endpackage

`default_nettype wire

// ==== rtl/pi_ctrl_macros.svh ====
`ifndef PI_CTRL_MACROS_SVH
`define PI_CTRL_MACROS_SVH

// ------------------------------------------------------------------------
// step hold-off
// ------------------------------------------------------------------------
// cycles after an accepted step or load in which requests are dropped
`define PI_STEP_GAP 4

// ------------------------------------------------------------------------
// command operation codes, carried on the decode to execute bus
// ------------------------------------------------------------------------
`define PI_OP_UP   2'd0   // advance phase by one
`define PI_OP_DN   2'd1   // retard phase by one
`define PI_OP_LOAD 2'd2   // jump to load_code

`endif
